//--- Bender.yml
package:
  name: srpt_grant

export_include_dirs:
  - .

sources:
  - files:
      - srpt_pkg.sv
      - grant_ctrl_fsm.sv
      - credit_counter.sv
      - header_match.sv
      - srpt_select.sv
      - active_set.sv
      - srpt_grant_top.sv
  - target: test
    files:
      - tb_srpt_grant.sv

//--- active_set.sv
`include "srpt_defs.svh"

module active_set (
   input  logic                                        ap_clk,
   input  logic                                        ap_rst,
   input  logic                                        hdr_commit_i,
   input  srpt_pkg::hdr_op_e                           hdr_op_i,
   input  logic [`SRPT_SLOT_IDX_W-1:0]                 hdr_slot_i,
   input  srpt_pkg::hdr_t                              hdr_data_i,
   input  logic                                        grant_fire_i,
   input  logic [`SRPT_SLOT_IDX_W-1:0]                 grant_slot_i,
   input  logic [`SRPT_PKT_CNT_W-1:0]                  grant_pkts_i,
   output srpt_pkg::entry_t [`SRPT_MAX_OVERCOMMIT-1:0] entries_o
);

   localparam logic [`SRPT_PKT_CNT_W-1:0] ONE_PKT = 1;

   srpt_pkg::entry_t [`SRPT_MAX_OVERCOMMIT-1:0] entries_q;
   srpt_pkg::hdr_t                              hdr_q;
   srpt_pkg::entry_t                            upd_entry;
   srpt_pkg::entry_t                            gnt_entry;
   logic [`SRPT_PKT_CNT_W-1:0]                  recv_left;
   logic [`SRPT_PKT_CNT_W-1:0]                  grantable_left;

   assign upd_entry = entries_q[hdr_slot_i];
   assign gnt_entry = entries_q[grant_slot_i];

   // Counts left in the granted slot after this grant
   assign recv_left      = gnt_entry.recv_pkts - grant_pkts_i;
   assign grantable_left = gnt_entry.grantable_pkts - grant_pkts_i;

   // FIFO word of the previous cycle, which is the accepted header during commit
   always_ff @(posedge ap_clk) begin
      hdr_q <= hdr_data_i;
   end

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         for (int i = 0; i < `SRPT_MAX_OVERCOMMIT; i++) begin
            entries_q[i].valid <= 1'b0;
         end
      end else if (hdr_commit_i) begin
         case (hdr_op_i)
            srpt_pkg::HDR_CREATE: begin
               entries_q[hdr_slot_i].valid          <= 1'b1;
               entries_q[hdr_slot_i].peer_id        <= hdr_q.peer_id;
               entries_q[hdr_slot_i].rpc_id         <= hdr_q.rpc_id;
               // The first packet itself counts as received
               entries_q[hdr_slot_i].recv_pkts      <= ONE_PKT;
               entries_q[hdr_slot_i].grantable_pkts <= hdr_q.msg_len - ONE_PKT;
            end
            srpt_pkg::HDR_UPDATE: begin
               entries_q[hdr_slot_i].recv_pkts      <= upd_entry.recv_pkts + ONE_PKT;
               entries_q[hdr_slot_i].grantable_pkts <= upd_entry.grantable_pkts - ONE_PKT;
            end
            default: begin
            end
         endcase
      end else if (grant_fire_i) begin
         entries_q[grant_slot_i].recv_pkts      <= recv_left;
         entries_q[grant_slot_i].grantable_pkts <= grantable_left;
         // Slot frees once nothing is left to grant
         if (grantable_left == '0 && recv_left == '0) begin
            entries_q[grant_slot_i].valid <= 1'b0;
         end
      end
   end

   assign entries_o = entries_q;

   // Selector and controller must only fire grants at live slots
   a_grant_slot_valid: assert property (@(posedge ap_clk) disable iff (ap_rst)
      grant_fire_i |-> entries_q[grant_slot_i].valid);

endmodule

//--- compile.f
+incdir+.
srpt_pkg.sv
grant_ctrl_fsm.sv
credit_counter.sv
header_match.sv
srpt_select.sv
active_set.sv
srpt_grant_top.sv
tb_srpt_grant.sv

//--- credit_counter.sv
`include "srpt_defs.svh"

module credit_counter #(
   parameter logic [`SRPT_PKT_CNT_W-1:0] CREDIT_PKTS = `SRPT_OVERCOMMIT_PKTS
) (
   input  logic                       ap_clk,
   input  logic                       ap_rst,
   input  logic                       grant_fire_i,
   input  logic [`SRPT_PKT_CNT_W-1:0] grant_pkts_i,
   output logic [`SRPT_PKT_CNT_W-1:0] credit_o
);

   logic [`SRPT_PKT_CNT_W-1:0] credit_q;

   // Overcommit budget, spent by grants and never refilled
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         credit_q <= CREDIT_PKTS;
      end else if (grant_fire_i) begin
         credit_q <= credit_q - grant_pkts_i;
      end
   end

   assign credit_o = credit_q;

   // The selector must cap every grant at the remaining budget
   a_no_underflow: assert property (@(posedge ap_clk) disable iff (ap_rst)
      grant_fire_i |-> (grant_pkts_i <= credit_q));

endmodule

//--- grant_ctrl_fsm.sv
module grant_ctrl_fsm (
   input  logic ap_clk,
   input  logic ap_rst,
   input  logic hdr_empty_i,
   input  logic grant_full_i,
   input  logic grant_ready_i,
   output logic hdr_accept_o,
   output logic hdr_commit_o,
   output logic grant_fire_o
);

   srpt_pkg::ctrl_state_e state_q;
   srpt_pkg::ctrl_state_e state_d;

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         state_q <= srpt_pkg::CTRL_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d      = state_q;
      hdr_accept_o = 1'b0;
      case (state_q)
         srpt_pkg::CTRL_IDLE: begin
            // Headers win over grants
            if (!hdr_empty_i) begin
               hdr_accept_o = 1'b1;
               state_d      = srpt_pkg::CTRL_COMMIT;
            end else if (grant_ready_i && !grant_full_i) begin
               state_d = srpt_pkg::CTRL_GRANT;
            end
         end
         // Both one-cycle states fall back to idle
         srpt_pkg::CTRL_COMMIT: state_d = srpt_pkg::CTRL_IDLE;
         srpt_pkg::CTRL_GRANT:  state_d = srpt_pkg::CTRL_IDLE;
         default:               state_d = srpt_pkg::CTRL_IDLE;
      endcase
   end

   assign hdr_commit_o = (state_q == srpt_pkg::CTRL_COMMIT);
   assign grant_fire_o = (state_q == srpt_pkg::CTRL_GRANT);

   // Table writes from a header and a grant never collide
   a_commit_grant_excl: assert property (@(posedge ap_clk) disable iff (ap_rst)
      !(hdr_commit_o && grant_fire_o));

endmodule

//--- header_match.sv
`include "srpt_defs.svh"

module header_match (
   input  logic                                        ap_clk,
   input  logic                                        ap_rst,
   input  logic                                        hdr_accept_i,
   input  srpt_pkg::hdr_t                              hdr_data_i,
   input  srpt_pkg::entry_t [`SRPT_MAX_OVERCOMMIT-1:0] entries_i,
   output srpt_pkg::hdr_op_e                           hdr_op_o,
   output logic [`SRPT_SLOT_IDX_W-1:0]                 hdr_slot_o
);

   localparam logic [`SRPT_PKT_CNT_W-1:0] RTT_PKTS = `SRPT_RTT_PKTS;

   srpt_pkg::hdr_t              hdr_q;
   logic                        match_hit;
   logic [`SRPT_SLOT_IDX_W-1:0] match_slot;
   logic                        free_hit;
   logic [`SRPT_SLOT_IDX_W-1:0] free_slot;

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         hdr_q <= '0;
      end else if (hdr_accept_i) begin
         hdr_q <= hdr_data_i;
      end
   end

   // First valid slot holding this peer and RPC, and first empty slot
   always_comb begin
      match_hit  = 1'b0;
      match_slot = '0;
      free_hit   = 1'b0;
      free_slot  = '0;
      for (int i = 0; i < `SRPT_MAX_OVERCOMMIT; i++) begin
         if (entries_i[i].valid) begin
            if (!match_hit && entries_i[i].peer_id == hdr_q.peer_id &&
                entries_i[i].rpc_id == hdr_q.rpc_id) begin
               match_hit  = 1'b1;
               match_slot = i[`SRPT_SLOT_IDX_W-1:0];
            end
         end else if (!free_hit) begin
            free_hit  = 1'b1;
            free_slot = i[`SRPT_SLOT_IDX_W-1:0];
         end
      end
   end

   always_comb begin
      hdr_op_o   = srpt_pkg::HDR_NONE;
      hdr_slot_o = '0;
      // Short messages never get scheduled
      if (hdr_q.msg_len > RTT_PKTS) begin
         if (hdr_q.offset == '0) begin
            // Repeated first packets of an active message are dropped
            if (!match_hit && free_hit) begin
               hdr_op_o   = srpt_pkg::HDR_CREATE;
               hdr_slot_o = free_slot;
            end
         end else if (match_hit) begin
            hdr_op_o   = srpt_pkg::HDR_UPDATE;
            hdr_slot_o = match_slot;
         end
      end
   end

endmodule

//--- srpt_defs.svh
`ifndef SRPT_DEFS_SVH
`define SRPT_DEFS_SVH

// Identifier widths carried in headers, entries and grants
`define SRPT_PEER_ID_W 14
`define SRPT_RPC_ID_W 14

// One width for every packet count in the design
`define SRPT_PKT_CNT_W 10

// Active set geometry
`define SRPT_MAX_OVERCOMMIT 8
`define SRPT_SLOT_IDX_W 3

// Messages of one RTT of packets or less go out unscheduled
`define SRPT_RTT_PKTS 44

// One RTT of packets for each active slot
`define SRPT_OVERCOMMIT_PKTS 352

`endif

//--- srpt_grant_top.sv
`include "srpt_defs.svh"

module srpt_grant_top #(
   parameter logic [`SRPT_PKT_CNT_W-1:0] CREDIT_PKTS = `SRPT_OVERCOMMIT_PKTS
) (
   input  logic            ap_clk,
   input  logic            ap_rst,
   input  logic            header_in_empty_i,
   output logic            header_in_read_en_o,
   input  srpt_pkg::hdr_t  header_in_data_i,
   input  logic            grant_pkt_full_i,
   output logic            grant_pkt_write_en_o,
   output srpt_pkg::grant_t grant_pkt_data_o
);

   logic                                       hdr_accept;
   logic                                       hdr_commit;
   logic                                       grant_fire;
   srpt_pkg::hdr_op_e                          hdr_op;
   logic [`SRPT_SLOT_IDX_W-1:0]                hdr_slot;
   logic                                       grant_ready;
   logic [`SRPT_SLOT_IDX_W-1:0]                grant_slot;
   logic [`SRPT_PKT_CNT_W-1:0]                 grant_pkts;
   logic [`SRPT_PKT_CNT_W-1:0]                 credit;
   srpt_pkg::entry_t [`SRPT_MAX_OVERCOMMIT-1:0] entries;

   // FIFO strobes come straight from the controller
   assign header_in_read_en_o  = hdr_accept;
   assign grant_pkt_write_en_o = grant_fire;

   grant_ctrl_fsm u_ctrl (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .hdr_empty_i   (header_in_empty_i),
      .grant_full_i  (grant_pkt_full_i),
      .grant_ready_i (grant_ready),
      .hdr_accept_o  (hdr_accept),
      .hdr_commit_o  (hdr_commit),
      .grant_fire_o  (grant_fire)
   );

   credit_counter #(
      .CREDIT_PKTS (CREDIT_PKTS)
   ) u_credit (
      .ap_clk       (ap_clk),
      .ap_rst       (ap_rst),
      .grant_fire_i (grant_fire),
      .grant_pkts_i (grant_pkts),
      .credit_o     (credit)
   );

   header_match u_match (
      .ap_clk       (ap_clk),
      .ap_rst       (ap_rst),
      .hdr_accept_i (hdr_accept),
      .hdr_data_i   (header_in_data_i),
      .entries_i    (entries),
      .hdr_op_o     (hdr_op),
      .hdr_slot_o   (hdr_slot)
   );

   srpt_select u_select (
      .entries_i     (entries),
      .credit_i      (credit),
      .grant_ready_o (grant_ready),
      .grant_slot_o  (grant_slot),
      .grant_pkts_o  (grant_pkts),
      .grant_data_o  (grant_pkt_data_o)
   );

   active_set u_active (
      .ap_clk       (ap_clk),
      .ap_rst       (ap_rst),
      .hdr_commit_i (hdr_commit),
      .hdr_op_i     (hdr_op),
      .hdr_slot_i   (hdr_slot),
      .hdr_data_i   (header_in_data_i),
      .grant_fire_i (grant_fire),
      .grant_slot_i (grant_slot),
      .grant_pkts_i (grant_pkts),
      .entries_o    (entries)
   );

endmodule

//--- srpt_pkg.sv
`include "srpt_defs.svh"

package srpt_pkg;

   // Header word as popped from the header FIFO, peer_id in the top bits
   typedef struct packed {
      logic [`SRPT_PEER_ID_W-1:0] peer_id;
      logic [`SRPT_RPC_ID_W-1:0]  rpc_id;
      logic [`SRPT_PKT_CNT_W-1:0] msg_len;
      logic [`SRPT_PKT_CNT_W-1:0] incoming;
      logic [`SRPT_PKT_CNT_W-1:0] offset;
   } hdr_t;

   // One slot of the active set
   typedef struct packed {
      logic                       valid;
      logic [`SRPT_PEER_ID_W-1:0] peer_id;
      logic [`SRPT_RPC_ID_W-1:0]  rpc_id;
      logic [`SRPT_PKT_CNT_W-1:0] recv_pkts;
      logic [`SRPT_PKT_CNT_W-1:0] grantable_pkts;
   } entry_t;

   // Record written to the grant FIFO
   typedef struct packed {
      logic [`SRPT_PEER_ID_W-1:0] peer_id;
      logic [`SRPT_RPC_ID_W-1:0]  rpc_id;
      logic [`SRPT_PKT_CNT_W-1:0] grant_pkts;
   } grant_t;

   typedef enum logic [1:0] {
      CTRL_IDLE   = 2'd0,
      CTRL_COMMIT = 2'd1,
      CTRL_GRANT  = 2'd2
   } ctrl_state_e;

   typedef enum logic [1:0] {
      HDR_NONE   = 2'd0,
      HDR_CREATE = 2'd1,
      HDR_UPDATE = 2'd2
   } hdr_op_e;

endpackage

//--- srpt_select.sv
`include "srpt_defs.svh"

module srpt_select (
   input  srpt_pkg::entry_t [`SRPT_MAX_OVERCOMMIT-1:0] entries_i,
   input  logic [`SRPT_PKT_CNT_W-1:0]                  credit_i,
   output logic                                        grant_ready_o,
   output logic [`SRPT_SLOT_IDX_W-1:0]                 grant_slot_o,
   output logic [`SRPT_PKT_CNT_W-1:0]                  grant_pkts_o,
   output srpt_pkg::grant_t                            grant_data_o
);

   logic                        sel_hit;
   logic [`SRPT_SLOT_IDX_W-1:0] sel_slot;
   logic [`SRPT_PKT_CNT_W-1:0]  sel_grantable;
   srpt_pkg::entry_t            sel_entry;

   // Shortest remaining first; strict compare keeps the lower slot on ties
   always_comb begin
      sel_hit       = 1'b0;
      sel_slot      = '0;
      sel_grantable = '1;
      for (int i = 0; i < `SRPT_MAX_OVERCOMMIT; i++) begin
         if (entries_i[i].valid && entries_i[i].recv_pkts != '0 && credit_i != '0) begin
            if (!sel_hit || entries_i[i].grantable_pkts < sel_grantable) begin
               sel_hit       = 1'b1;
               sel_slot      = i[`SRPT_SLOT_IDX_W-1:0];
               sel_grantable = entries_i[i].grantable_pkts;
            end
         end
      end
   end

   assign sel_entry     = entries_i[sel_slot];
   assign grant_ready_o = sel_hit;
   assign grant_slot_o  = sel_slot;

   // Grant what has arrived, but no more than the budget left
   assign grant_pkts_o = (sel_entry.recv_pkts < credit_i) ? sel_entry.recv_pkts : credit_i;

   assign grant_data_o.peer_id    = sel_entry.peer_id;
   assign grant_data_o.rpc_id     = sel_entry.rpc_id;
   assign grant_data_o.grant_pkts = grant_pkts_o;

endmodule

//--- tb_srpt_grant.sv
`include "srpt_defs.svh"

module tb_srpt_grant;

   localparam int CREDIT      = 30;
   localparam int N_MSGS      = 12;
   localparam int N_SLOTS     = `SRPT_MAX_OVERCOMMIT;
   localparam int HOLD        = 3;
   localparam int N_PHASES    = 5;
   localparam int N_HEADERS   = 36;
   localparam int CYCLE_LIMIT = 4 * N_HEADERS + N_PHASES * (HOLD + 6) + 200;

   logic             ap_clk;
   logic             ap_rst;
   logic             header_in_empty_i;
   logic             header_in_read_en_o;
   srpt_pkg::hdr_t   header_in_data_i;
   logic             grant_pkt_full_i;
   logic             grant_pkt_write_en_o;
   srpt_pkg::grant_t grant_pkt_data_o;

   // Behavioural header FIFO and the expected grant stream
   srpt_pkg::hdr_t   hdr_fifo[$];
   srpt_pkg::grant_t expected_q[$];
   srpt_pkg::grant_t exp_grant;

   // Messages used by the tests, indexed by message number
   logic [`SRPT_PKT_CNT_W-1:0] msg_len  [N_MSGS];
   logic [`SRPT_PEER_ID_W-1:0] peer_ids [N_MSGS];
   logic [`SRPT_RPC_ID_W-1:0]  rpc_ids  [N_MSGS];

   // Reference copy of the active set and budget
   logic                       ref_valid [N_SLOTS];
   logic [`SRPT_PEER_ID_W-1:0] ref_peer  [N_SLOTS];
   logic [`SRPT_RPC_ID_W-1:0]  ref_rpc   [N_SLOTS];
   logic [`SRPT_PKT_CNT_W-1:0] ref_recv  [N_SLOTS];
   logic [`SRPT_PKT_CNT_W-1:0] ref_gtbl  [N_SLOTS];
   logic [`SRPT_PKT_CNT_W-1:0] ref_credit;

   logic [31:0] rnd;
   int          granted_total;
   int          cycle_count;

   srpt_grant_top #(
      .CREDIT_PKTS (CREDIT)
   ) UUT (
      .ap_clk               (ap_clk),
      .ap_rst               (ap_rst),
      .header_in_empty_i    (header_in_empty_i),
      .header_in_read_en_o  (header_in_read_en_o),
      .header_in_data_i     (header_in_data_i),
      .grant_pkt_full_i     (grant_pkt_full_i),
      .grant_pkt_write_en_o (grant_pkt_write_en_o),
      .grant_pkt_data_o     (grant_pkt_data_o)
   );

   initial begin
      ap_clk = 1'b0;
      forever #50 ap_clk = ~ap_clk;
   end

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         abort_run();
      end
   endtask

   task automatic drive_header_fifo();
      header_in_empty_i = (hdr_fifo.size() == 0);
      if (hdr_fifo.size() != 0) begin
         header_in_data_i = hdr_fifo[0];
      end
   endtask

   // Classify one header against the reference table and apply it
   function automatic void ref_header(input srpt_pkg::hdr_t h);
      int hit;
      int free_slot;
      hit       = -1;
      free_slot = -1;
      for (int i = 0; i < N_SLOTS; i++) begin
         if (ref_valid[i] && ref_peer[i] == h.peer_id && ref_rpc[i] == h.rpc_id && hit < 0) begin
            hit = i;
         end
         if (!ref_valid[i] && free_slot < 0) begin
            free_slot = i;
         end
      end
      if (h.msg_len > `SRPT_RTT_PKTS) begin
         if (h.offset == 0) begin
            if (hit < 0 && free_slot >= 0) begin
               ref_valid[free_slot] = 1'b1;
               ref_peer[free_slot]  = h.peer_id;
               ref_rpc[free_slot]   = h.rpc_id;
               ref_recv[free_slot]  = 1;
               ref_gtbl[free_slot]  = h.msg_len - 1;
            end
         end else if (hit >= 0) begin
            ref_recv[hit] = ref_recv[hit] + 1;
            ref_gtbl[hit] = ref_gtbl[hit] - 1;
         end
      end
   endfunction

   // Next SRPT grant of the reference table, zero when nothing is ready
   function automatic bit next_ref_grant(output srpt_pkg::grant_t g);
      int                         sel;
      logic [`SRPT_PKT_CNT_W-1:0] amount;
      sel = -1;
      g   = '0;
      for (int i = 0; i < N_SLOTS; i++) begin
         if (ref_valid[i] && ref_recv[i] != 0 && ref_credit != 0) begin
            if (sel < 0 || ref_gtbl[i] < ref_gtbl[sel]) begin
               sel = i;
            end
         end
      end
      if (sel < 0) begin
         return 1'b0;
      end
      amount         = (ref_recv[sel] < ref_credit) ? ref_recv[sel] : ref_credit;
      g.peer_id      = ref_peer[sel];
      g.rpc_id       = ref_rpc[sel];
      g.grant_pkts   = amount;
      ref_recv[sel]  = ref_recv[sel] - amount;
      ref_gtbl[sel]  = ref_gtbl[sel] - amount;
      ref_credit     = ref_credit - amount;
      if (ref_gtbl[sel] == 0 && ref_recv[sel] == 0) begin
         ref_valid[sel] = 1'b0;
      end
      return 1'b1;
   endfunction

   function automatic void queue_ref_grants(input int max_count);
      srpt_pkg::grant_t g;
      int               n;
      n = 0;
      while (n < max_count && next_ref_grant(g)) begin
         expected_q.push_back(g);
         n++;
      end
   endfunction

   task automatic push_header(input int idx, input logic [`SRPT_PKT_CNT_W-1:0] offset);
      srpt_pkg::hdr_t h;
      h.peer_id  = peer_ids[idx];
      h.rpc_id   = rpc_ids[idx];
      h.msg_len  = msg_len[idx];
      h.incoming = '0;
      h.offset   = offset;
      hdr_fifo.push_back(h);
      ref_header(h);
      drive_header_fifo();
   endtask

   // Headers drained and committed, then a few idle cycles with full unchanged
   task automatic settle_headers();
      while (hdr_fifo.size() != 0) begin
         @(negedge ap_clk);
      end
      repeat (2 + HOLD) @(negedge ap_clk);
   endtask

   task automatic finish_grants();
      while (expected_q.size() != 0) begin
         @(negedge ap_clk);
      end
      // Window to catch a grant nobody expected
      repeat (4) @(negedge ap_clk);
      grant_pkt_full_i = 1'b1;
   endtask

   task automatic release_and_drain();
      settle_headers();
      queue_ref_grants(N_SLOTS * CREDIT);
      grant_pkt_full_i = 1'b0;
      finish_grants();
   endtask

   task automatic wait_for_grant_write();
      while (!grant_pkt_write_en_o) begin
         @(negedge ap_clk);
      end
   endtask

   always @(negedge ap_clk) begin
      drive_header_fifo();
   end

   // Header FIFO pops on read enable
   always @(posedge ap_clk) begin
      if (header_in_read_en_o) begin
         if (hdr_fifo.size() == 0) begin
            $display("Header FIFO read while it was empty");
            abort_run();
         end else begin
            void'(hdr_fifo.pop_front());
         end
      end
   end

   // Every grant write is compared with the next expected record
   always @(posedge ap_clk) begin
      if (!ap_rst && grant_pkt_write_en_o) begin
         if (grant_pkt_full_i) begin
            $display("Grant written while the grant FIFO was full");
            abort_run();
         end else if (expected_q.size() == 0) begin
            $display("Grant written when no grant was expected");
            abort_run();
         end else begin
            exp_grant = expected_q.pop_front();
            check_value("grant_pkt_data_o.peer_id", grant_pkt_data_o.peer_id, exp_grant.peer_id);
            check_value("grant_pkt_data_o.rpc_id", grant_pkt_data_o.rpc_id, exp_grant.rpc_id);
            check_value("grant_pkt_data_o.grant_pkts", grant_pkt_data_o.grant_pkts,
                        exp_grant.grant_pkts);
            granted_total = granted_total + grant_pkt_data_o.grant_pkts;
         end
      end
   end

   always @(posedge ap_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   initial begin
      ap_rst            = 1'b1;
      header_in_empty_i = 1'b1;
      header_in_data_i  = '0;
      grant_pkt_full_i  = 1'b1;
      granted_total     = 0;
      cycle_count       = 0;
      ref_credit        = CREDIT;
      rnd               = $urandom(32'h3f0d_fe99);
      for (int i = 0; i < N_SLOTS; i++) begin
         ref_valid[i] = 1'b0;
      end
      // Low RPC bits carry the message number so identifiers never collide
      for (int i = 0; i < N_MSGS; i++) begin
         rnd         = $urandom;
         peer_ids[i] = rnd[13:0];
         rpc_ids[i]  = {rnd[23:14], i[3:0]};
      end
      msg_len = '{46, 60, 50, 50, 70, 48, 55, 65, 80, 45, 44, 100};
      repeat (2) @(negedge ap_clk);
      ap_rst = 1'b0;

      // Short message and a stray data packet get nothing
      push_header(10, 0);
      push_header(11, 5);
      release_and_drain();

      // First packet of a long message
      push_header(0, 0);
      release_and_drain();

      // Data packets pile up behind a full grant FIFO
      for (int off = 1; off <= 3; off++) begin
         push_header(0, off);
      end
      release_and_drain();

      // Seven more messages fill the set, the ninth is refused, message 0 completes
      for (int m = 1; m <= 8; m++) begin
         push_header(m, 0);
      end
      for (int off = 4; off <= 22; off++) begin
         push_header(0, off);
      end
      settle_headers();
      queue_ref_grants(1);
      grant_pkt_full_i = 1'b0;
      wait_for_grant_write();
      // New message takes the freed slot before the other grants go out
      push_header(9, 0);
      queue_ref_grants(N_SLOTS * CREDIT);
      finish_grants();

      // Budget is gone, so more data brings no grant
      push_header(4, 1);
      push_header(9, 1);
      release_and_drain();

      // The whole budget went out, and not a packet more
      check_value("total granted packets", granted_total, CREDIT);
      $display("all tests passed");
      $finish;
   end

endmodule
